//--- apb_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module apb_bridge_assertions (
    input wire logic              aclk,
    input wire logic              aresetn,
    input wire apb_pkg::apb_req_t i_req,
    input wire logic              i_done
);

    // Access phase only after exactly one setup cycle
    a_setup_first: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(i_req.penable) |-> $past(i_req.psel) && !$past(i_req.penable))
        else $error("access phase without setup phase");

    a_setup_one_cycle: assert property (@(posedge aclk) disable iff (!aresetn)
        i_req.psel && !i_req.penable |=> i_req.psel && i_req.penable)
        else $error("setup phase not followed by access phase");

    a_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        i_req.psel && !i_done |=>
            $stable(i_req.paddr) && $stable(i_req.pwdata) && $stable(i_req.pwrite))
        else $error("address or write data changed during a transfer");

    a_penable_psel: assert property (@(posedge aclk) disable iff (!aresetn)
        i_req.penable |-> i_req.psel)
        else $error("penable high without psel");

endmodule

bind apb_cmd_master apb_bridge_assertions u_apb_assertions (
    .aclk    (aclk),
    .aresetn (aresetn),
    .i_req   (o_apb),
    .i_done  (w_done)
);

`default_nettype wire

//--- apb_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module apb_bridge_top #(
    parameter int NUM_REGS    = 16,
    parameter int WAIT_STATES = 1
) (
    input  wire logic              aclk,
    input  wire logic              aresetn,
    input  wire logic              i_cmd_valid,
    output logic                   o_cmd_ready,
    input  wire apb_pkg::apb_cmd_t i_cmd,
    output logic                   o_rsp_valid,
    input  wire logic              i_rsp_ready,
    output apb_pkg::apb_rsp_t      o_rsp
);

    apb_pkg::apb_req_t apb_req;
    apb_pkg::apb_cpl_t apb_cpl;

    apb_cmd_master u_master (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd       (i_cmd),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp),
        .o_apb       (apb_req),
        .i_apb       (apb_cpl)
    );

    apb_reg_slave #(
        .NUM_REGS    (NUM_REGS),
        .WAIT_STATES (WAIT_STATES)
    ) u_slave (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_apb   (apb_req),
        .o_apb   (apb_cpl)
    );

endmodule

`default_nettype wire

//--- apb_bridge_vectors.txt
# write prot strb addr wdata exp_slverr exp_rdata, all hex
# one APB transaction per line, responses expected in this order
0 0 f 00000000 00000000 0 00000000
0 0 f 00000014 00000000 0 00000000
1 0 f 00000000 deadbeef 0 00000000
0 0 f 00000000 00000000 0 deadbeef
1 2 f 00000004 12345678 0 00000000
0 2 f 00000004 00000000 0 12345678
1 0 3 00000000 0000aaaa 0 00000000
0 0 f 00000000 00000000 0 deadaaaa
1 1 4 00000000 00550000 0 00000000
0 0 f 00000000 00000000 0 de55aaaa
1 0 f 00000040 ffffffff 1 00000000
0 0 f 00000040 00000000 1 00000000
1 0 f 00000006 ffffffff 1 00000000
0 0 f 00000005 00000000 1 00000000
0 0 f 00000004 00000000 0 12345678
1 0 f 0000003c a5a5a5a5 0 00000000
0 0 f 0000003c 00000000 0 a5a5a5a5
0 0 0 00000000 00000000 0 de55aaaa

//--- apb_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module apb_cmd_master (
    input  wire logic              aclk,
    input  wire logic              aresetn,
    input  wire logic              i_cmd_valid,
    output logic                   o_cmd_ready,
    input  wire apb_pkg::apb_cmd_t i_cmd,
    output logic                   o_rsp_valid,
    input  wire logic              i_rsp_ready,
    output apb_pkg::apb_rsp_t      o_rsp,
    output apb_pkg::apb_req_t      o_apb,
    input  wire apb_pkg::apb_cpl_t i_apb
);

    localparam int CMD_WIDTH = $bits(apb_pkg::apb_cmd_t);
    localparam int RSP_WIDTH = $bits(apb_pkg::apb_rsp_t);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } state_t;

    state_t            r_state;
    state_t            w_next_state;

    logic              w_cmd_valid;
    logic              w_cmd_ready;
    apb_pkg::apb_cmd_t w_cmd;
    apb_pkg::apb_cmd_t r_cmd;

    logic              w_rsp_valid;
    logic              w_rsp_ready;
    apb_pkg::apb_rsp_t w_rsp;

    logic              w_done;

    skid_buffer #(
        .DATA_WIDTH(CMD_WIDTH)
    ) u_cmd_skid (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_valid (i_cmd_valid),
        .o_ready (o_cmd_ready),
        .i_data  (i_cmd),
        .o_valid (w_cmd_valid),
        .i_ready (w_cmd_ready),
        .o_data  (w_cmd)
    );

    skid_buffer #(
        .DATA_WIDTH(RSP_WIDTH)
    ) u_rsp_skid (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_valid (w_rsp_valid),
        .o_ready (w_rsp_ready),
        .i_data  (w_rsp),
        .o_valid (o_rsp_valid),
        .i_ready (i_rsp_ready),
        .o_data  (o_rsp)
    );

    // Completion waits for room in the response buffer, pready alone is not enough
    assign w_done      = (r_state == ACCESS) && i_apb.pready && w_rsp_ready;
    assign w_cmd_ready = (r_state == IDLE) || w_done;
    assign w_rsp_valid = w_done;

    always_comb begin
        w_rsp.slverr = i_apb.pslverr;
        w_rsp.rdata  = (!r_cmd.write && !i_apb.pslverr) ? i_apb.prdata : '0;
    end

    always_comb begin
        w_next_state = r_state;
        case (r_state)
            IDLE: begin
                if (w_cmd_valid) begin
                    w_next_state = SETUP;
                end
            end
            SETUP: w_next_state = ACCESS;
            ACCESS: begin
                if (w_done) begin
                    w_next_state = w_cmd_valid ? SETUP : IDLE;
                end
            end
            default: w_next_state = IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    // Held command keeps the bus fields stable for the whole transfer
    always_ff @(posedge aclk) begin
        if (w_cmd_valid && w_cmd_ready) begin
            r_cmd <= w_cmd;
        end
    end

    always_comb begin
        o_apb.psel    = (r_state != IDLE);
        o_apb.penable = (r_state == ACCESS);
        o_apb.pwrite  = r_cmd.write;
        o_apb.pprot   = r_cmd.prot;
        o_apb.pstrb   = r_cmd.strb;
        o_apb.paddr   = r_cmd.addr;
        o_apb.pwdata  = r_cmd.wdata;
    end

endmodule

`default_nettype wire

//--- apb_pkg.sv
`default_nettype none

package apb_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  prot_t;

    // One command per APB transfer
    typedef struct packed {
        logic  write;
        prot_t prot;
        strb_t strb;
        addr_t addr;
        data_t wdata;
    } apb_cmd_t;

    // Rdata is zero for writes and errors
    typedef struct packed {
        logic  slverr;
        data_t rdata;
    } apb_rsp_t;

    // Master-driven APB signals
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        prot_t pprot;
        strb_t pstrb;
        addr_t paddr;
        data_t pwdata;
    } apb_req_t;

    // Slave-driven APB signals
    typedef struct packed {
        logic  pready;
        logic  pslverr;
        data_t prdata;
    } apb_cpl_t;

endpackage

`default_nettype wire

//--- apb_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module apb_reg_slave #(
    parameter int NUM_REGS    = 16,
    parameter int WAIT_STATES = 1
) (
    input  wire logic              aclk,
    input  wire logic              aresetn,
    input  wire apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_cpl_t      o_apb
);

    localparam int IDX_W = $clog2(NUM_REGS);
    localparam int CNT_W = $clog2(WAIT_STATES + 2);
    localparam apb_pkg::addr_t ADDR_LIMIT = apb_pkg::addr_t'(4 * NUM_REGS);

    apb_pkg::data_t   r_regs [NUM_REGS];
    logic [CNT_W-1:0] r_wait_cnt;
    logic [IDX_W-1:0] w_idx;
    logic             w_access;
    logic             w_ready;
    logic             w_commit;
    logic             w_err;

    assign w_idx    = i_apb.paddr[IDX_W+1:2];
    assign w_access = i_apb.psel && i_apb.penable;
    assign w_err    = (i_apb.paddr >= ADDR_LIMIT) || (i_apb.paddr[1:0] != 2'b00);

    // Counter runs one past WAIT_STATES so the commit cycle is seen only once
    assign w_ready  = w_access && (r_wait_cnt >= CNT_W'(WAIT_STATES));
    assign w_commit = w_access && (r_wait_cnt == CNT_W'(WAIT_STATES));

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_wait_cnt <= '0;
        end else if (!w_access) begin
            r_wait_cnt <= '0;
        end else if (r_wait_cnt != CNT_W'(WAIT_STATES + 1)) begin
            r_wait_cnt <= r_wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                r_regs[i] <= '0;
            end
        end else if (w_commit && i_apb.pwrite && !w_err) begin
            // Byte lanes follow pstrb
            for (int b = 0; b < 4; b++) begin
                if (i_apb.pstrb[b]) begin
                    r_regs[w_idx][8*b +: 8] <= i_apb.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        o_apb.pready  = w_ready;
        o_apb.pslverr = w_ready && w_err;
        o_apb.prdata  = (w_ready && !i_apb.pwrite && !w_err) ? r_regs[w_idx] : '0;
    end

endmodule

`default_nettype wire

//--- skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,
    input  wire logic                  i_valid,
    output logic                       o_ready,
    input  wire logic [DATA_WIDTH-1:0] i_data,
    output logic                       o_valid,
    input  wire logic                  i_ready,
    output logic [DATA_WIDTH-1:0]      o_data
);

    logic                  r_skid_valid;
    logic [DATA_WIDTH-1:0] r_skid_data;
    logic                  w_main_load;
    logic                  w_in_fire;

    // Main register may take a new beat when empty or being drained
    assign w_main_load = !o_valid || i_ready;
    assign w_in_fire   = i_valid && o_ready;

    // Only a full skid entry stops the input
    assign o_ready = !r_skid_valid;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_valid      <= 1'b0;
            r_skid_valid <= 1'b0;
        end else if (w_main_load) begin
            o_valid      <= r_skid_valid || i_valid;
            r_skid_valid <= 1'b0;
        end else if (w_in_fire) begin
            r_skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (w_main_load) begin
            // Skid entry is older, so it goes first
            if (r_skid_valid) begin
                o_data <= r_skid_data;
            end else if (i_valid) begin
                o_data <= i_data;
            end
        end else if (w_in_fire) begin
            r_skid_data <= i_data;
        end
    end

endmodule

`default_nettype wire

//--- src.f
apb_pkg.sv
skid_buffer.sv
apb_cmd_master.sv
apb_reg_slave.sv
apb_bridge_top.sv
apb_bridge_assertions.sv
tb_apb_bridge.sv

//--- tb_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_apb_bridge;

    localparam int NUM_REGS    = 16;
    localparam int WAIT_STATES = 1;

    logic              aclk;
    logic              aresetn;
    logic              i_cmd_valid;
    logic              o_cmd_ready;
    apb_pkg::apb_cmd_t i_cmd;
    logic              o_rsp_valid;
    logic              i_rsp_ready;
    apb_pkg::apb_rsp_t o_rsp;

    apb_pkg::apb_cmd_t cmd_q[$];
    apb_pkg::apb_rsp_t exp_q[$];
    int                rsp_count;
    int                cycles;
    int                cycle_limit;
    int                mismatch_errors;
    int                other_errors;

    apb_bridge_top #(
        .NUM_REGS    (NUM_REGS),
        .WAIT_STATES (WAIT_STATES)
    ) i_dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd       (i_cmd),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp)
    );

    always #20 aclk = ~aclk;

    always @(posedge aclk) begin
        if (aresetn) begin
            cycles <= cycles + 1;
        end
    end

    always @(posedge aclk) begin
        if (aresetn && o_rsp_valid && i_rsp_ready) begin
            assert (rsp_count < exp_q.size()) else begin
                other_errors++;
                $display("Extra response beyond the last vector");
            end
            if (rsp_count < exp_q.size()) begin
                assert (o_rsp.slverr == exp_q[rsp_count].slverr) else begin
                    mismatch_errors++;
                    $display("Mismatch o_rsp.slverr: got %h expected %h (response %0d)",
                        o_rsp.slverr, exp_q[rsp_count].slverr, rsp_count);
                end
                assert (o_rsp.rdata == exp_q[rsp_count].rdata) else begin
                    mismatch_errors++;
                    $display("Mismatch o_rsp.rdata: got %h expected %h (response %0d)",
                        o_rsp.rdata, exp_q[rsp_count].rdata, rsp_count);
                end
            end
            rsp_count <= rsp_count + 1;
        end
    end

    task automatic load_vectors();
        int                fd;
        int                n;
        string             line;
        logic [31:0]       v_write;
        logic [31:0]       v_prot;
        logic [31:0]       v_strb;
        logic [31:0]       v_addr;
        logic [31:0]       v_wdata;
        logic [31:0]       v_err;
        logic [31:0]       v_rdata;
        apb_pkg::apb_cmd_t cmd;
        apb_pkg::apb_rsp_t rsp;
        fd = $fopen("apb_bridge_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open apb_bridge_vectors.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", v_write, v_prot, v_strb,
                        v_addr, v_wdata, v_err, v_rdata);
                    if (n == 7) begin
                        cmd.write  = v_write[0];
                        cmd.prot   = apb_pkg::prot_t'(v_prot);
                        cmd.strb   = apb_pkg::strb_t'(v_strb);
                        cmd.addr   = v_addr;
                        cmd.wdata  = v_wdata;
                        rsp.slverr = v_err[0];
                        rsp.rdata  = v_rdata;
                        cmd_q.push_back(cmd);
                        exp_q.push_back(rsp);
                    end else begin
                        $display("Malformed vector line: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Commands in file order with random idle gaps
    task automatic send_commands();
        int gap;
        foreach (cmd_q[i]) begin
            i_cmd_valid = 1'b1;
            i_cmd       = cmd_q[i];
            do @(posedge aclk); while (!o_cmd_ready);
            #2;
            i_cmd_valid = 1'b0;
            gap = ($urandom % 2) ? 0 : $urandom % 4;
            repeat (gap) begin
                @(posedge aclk);
                #2;
            end
        end
    endtask

    // Response ready one cycle in four so the response buffer fills up
    task automatic drive_rsp_ready();
        forever begin
            @(posedge aclk);
            #2;
            i_rsp_ready = ($urandom % 4) == 0;
        end
    endtask

    initial begin
        void'($urandom(32'hb598_883a));
        aclk            = 1'b0;
        aresetn         = 1'b0;
        i_cmd_valid     = 1'b0;
        i_cmd           = '0;
        i_rsp_ready     = 1'b0;
        rsp_count       = 0;
        cycles          = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        load_vectors();
        cycle_limit = exp_q.size() * (20 + WAIT_STATES);
        repeat (3) @(posedge aclk);
        #2;
        aresetn = 1'b1;
        if (exp_q.size() == 0) begin
            $display("No vectors loaded");
            other_errors++;
        end else begin
            fork
                send_commands();
                drive_rsp_ready();
            join_none
            while (rsp_count < exp_q.size() && cycles < cycle_limit) @(posedge aclk);
            if (rsp_count < exp_q.size()) begin
                $display("timeout: responses missing");
                other_errors++;
            end else begin
                // Give a duplicate response time to show up
                repeat (10) @(posedge aclk);
            end
        end
        $display("Responses %0d of %0d, mismatches %0d, other errors %0d",
            rsp_count, exp_q.size(), mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
